// File: design/isa_pkg.sv
`default_nettype none

package isa_pkg;

    localparam int unsigned XLEN = 64;

    localparam logic [XLEN-1:0] RESET_PC    = 64'h0000_0000_c000_0000; // first fetch address
    localparam logic [XLEN-1:0] TRAP_VECTOR = 64'h0000_0000_8000_0100; // fixed handler entry

    typedef enum logic [5:0] {
        exc_fetch_misalign = 6'd0,
        exc_illegal_inst   = 6'd2,
        exc_breakpoint     = 6'd3,
        exc_load_fault     = 6'd5,
        exc_store_fault    = 6'd7,
        exc_ecall          = 6'd11
    } exc_cause_t;

    typedef struct packed {
        exc_cause_t  cause;
        logic [57:0] tval;  // upper tval bits dropped
    } trap_info_t;

    // one execute word, read by the entry's excp flag
    typedef union packed {
        logic [XLEN-1:0] npc;   // excp clear
        trap_info_t      trap;  // excp set
    } exe_result_u;

endpackage

`default_nettype wire

// File: design/rob_pkg.sv
`default_nettype none

package rob_pkg;

    localparam int unsigned ROB_DEPTH      = 16;
    localparam int unsigned ROB_IDX_W      = $clog2(ROB_DEPTH);
    localparam int unsigned DISPATCH_WIDTH = 2;
    localparam int unsigned EXE_WIDTH      = 2;
    localparam int unsigned COMMIT_WIDTH   = 2;

    typedef logic [ROB_IDX_W-1:0] rob_idx_t;
    typedef logic [ROB_IDX_W:0]   rob_cnt_t;  // holds 0 .. ROB_DEPTH

    typedef struct packed {
        logic                     valid;
        rob_idx_t                 idx;         // preallocated slot
        logic [isa_pkg::XLEN-1:0] pc;
        logic                     compressed;  // 16-bit encoding
    } dispatch_bundle_t;

    typedef struct packed {
        logic                 valid;
        rob_idx_t             idx;
        logic                 excp;    // result holds trap info
        isa_pkg::exe_result_u result;
    } exe_bundle_t;

    // decode side RAM word
    typedef struct packed {
        logic [isa_pkg::XLEN-1:0] pc;
        logic                     compressed;
    } rob_entry_t;

    // execute side RAM word
    typedef struct packed {
        logic                 excp;
        isa_pkg::exe_result_u result;
    } rob_result_t;

    typedef struct packed {
        logic                     valid;
        rob_idx_t                 idx;
        logic [isa_pkg::XLEN-1:0] pc;
        logic [isa_pkg::XLEN-1:0] npc;
    } commit_bundle_t;

    typedef struct packed {
        logic                     valid;
        logic [isa_pkg::XLEN-1:0] target;
    } redirect_t;

endpackage

`default_nettype wire

// File: design/mwp_ram.sv
`timescale 1ns/100ps
`default_nettype none

module mwp_ram #(
    parameter int unsigned width  = 64,
    parameter int unsigned depth  = 16,
    parameter int unsigned wports = 2,
    parameter int unsigned rports = 2
) (
    input  logic                                 clk,
    input  logic [wports-1:0][$clog2(depth)-1:0] waddr,
    input  logic [wports-1:0][width-1:0]         wdata,
    input  logic [wports-1:0]                    wen,
    input  logic [rports-1:0][$clog2(depth)-1:0] raddr,
    output logic [rports-1:0][width-1:0]         rdata
);

    logic [width-1:0] mem [depth];

    always_ff @(posedge clk) begin
        for (int p = 0; p < wports; p++) begin
            if (wen[p]) begin
                mem[waddr[p]] <= wdata[p];  // higher port wins on conflict
            end
        end
    end

    always_comb begin
        for (int p = 0; p < rports; p++) begin
            rdata[p] = mem[raddr[p]];  // async read
        end
    end

endmodule

`default_nettype wire

// File: design/rob_writeback.sv
`timescale 1ns/100ps
`default_nettype none

module rob_writeback (
    input  logic                                                 clk,
    input  logic                                                 rst,
    input  logic                                                 clear,
    input  rob_pkg::rob_idx_t                                    front,
    input  rob_pkg::rob_cnt_t                                    count,
    input  rob_pkg::dispatch_bundle_t [rob_pkg::DISPATCH_WIDTH-1:0] dispatch,
    input  rob_pkg::exe_bundle_t [rob_pkg::EXE_WIDTH-1:0]        exe_wb,
    input  rob_pkg::rob_idx_t [rob_pkg::COMMIT_WIDTH-1:0]        raddr,
    output rob_pkg::rob_idx_t [rob_pkg::DISPATCH_WIDTH-1:0]      ent_waddr,
    output rob_pkg::rob_entry_t [rob_pkg::DISPATCH_WIDTH-1:0]    ent_wdata,
    output logic [rob_pkg::DISPATCH_WIDTH-1:0]                   ent_wen,
    output rob_pkg::rob_idx_t [rob_pkg::EXE_WIDTH-1:0]           res_waddr,
    output rob_pkg::rob_result_t [rob_pkg::EXE_WIDTH-1:0]        res_wdata,
    output logic [rob_pkg::EXE_WIDTH-1:0]                        res_wen,
    input  rob_pkg::rob_result_t [rob_pkg::COMMIT_WIDTH-1:0]     res_rdata,
    output logic [rob_pkg::ROB_DEPTH-1:0]                        finished,
    output rob_pkg::rob_result_t [rob_pkg::COMMIT_WIDTH-1:0]     res_fwd,
    output rob_pkg::rob_cnt_t                                    alloc_cnt
);
    import rob_pkg::*;

    logic [ROB_DEPTH-1:0] done_q;  // registered finished bits
    logic [ROB_DEPTH-1:0] wb_hit;  // slots written back this cycle
    logic [ROB_DEPTH-1:0] live;    // slots inside front .. front+count

    always_comb begin
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            ent_waddr[i]            = dispatch[i].idx;
            ent_wen[i]              = dispatch[i].valid;
            ent_wdata[i].pc         = dispatch[i].pc;
            ent_wdata[i].compressed = dispatch[i].compressed;
        end
        for (int j = 0; j < EXE_WIDTH; j++) begin
            res_waddr[j]        = exe_wb[j].idx;
            res_wen[j]          = exe_wb[j].valid;
            res_wdata[j].excp   = exe_wb[j].excp;
            res_wdata[j].result = exe_wb[j].result;
        end
    end

    // a slot already inside the window is a rewrite, not a new entry
    always_comb begin
        alloc_cnt = '0;
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            if (dispatch[i].valid && ({1'b0, dispatch[i].idx - front} >= count)) begin
                alloc_cnt = alloc_cnt + rob_cnt_t'(1);
            end
        end
    end

    always_comb begin
        wb_hit = '0;
        for (int j = 0; j < EXE_WIDTH; j++) begin
            if (exe_wb[j].valid) begin
                wb_hit[exe_wb[j].idx] = 1'b1;
            end
        end
        for (int s = 0; s < ROB_DEPTH; s++) begin
            live[s] = {1'b0, rob_idx_t'(s) - front} < count;  // wraps with the ring
        end
    end

    // committed slots fall out of the window and drop their bit one cycle later
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            done_q <= '0;
        end else begin
            done_q <= (done_q & live) | wb_hit;
        end
    end

    assign finished = done_q | wb_hit;  // same-cycle writeback visible

    always_comb begin
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            res_fwd[i] = res_rdata[i];
            for (int j = 0; j < EXE_WIDTH; j++) begin
                if (exe_wb[j].valid && (exe_wb[j].idx == raddr[i])) begin
                    res_fwd[i] = res_wdata[j];  // bypass the RAM
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: design/rob_commit_select.sv
`timescale 1ns/100ps
`default_nettype none

module rob_commit_select (
    input  logic                                             clk,
    input  logic                                             rst,
    input  rob_pkg::rob_entry_t [rob_pkg::COMMIT_WIDTH-1:0]  ent_rdata,
    input  rob_pkg::rob_result_t [rob_pkg::COMMIT_WIDTH-1:0] res_fwd,
    input  logic [rob_pkg::ROB_DEPTH-1:0]                    finished,
    input  rob_pkg::rob_cnt_t                                alloc_cnt,
    output rob_pkg::rob_idx_t [rob_pkg::COMMIT_WIDTH-1:0]    raddr,
    output rob_pkg::rob_idx_t                                front,
    output rob_pkg::rob_cnt_t                                count,
    output logic [rob_pkg::COMMIT_WIDTH-1:0]                 commit_en,
    output logic                                             mispredict,
    output logic                                             head_excp,
    output logic                                             clear,
    output logic [isa_pkg::XLEN-1:0]                         last_npc
);
    import rob_pkg::*;
    import isa_pkg::*;

    rob_cnt_t        n_commit;  // lanes retiring this cycle
    logic [XLEN-1:0] npc_next;  // npc of youngest retiring lane

    always_comb begin
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            raddr[i] = front + rob_idx_t'(i);
        end
    end

    // head is checked as soon as it is dispatched, finished or not
    always_comb begin
        mispredict = (count != '0) && (ent_rdata[0].pc != last_npc);
        head_excp  = (count != '0) && !mispredict && finished[raddr[0]] && res_fwd[0].excp;
        clear      = mispredict || head_excp;
    end

    always_comb begin
        logic            chain_ok;
        logic [XLEN-1:0] chain_npc;
        chain_ok  = 1'b1;
        chain_npc = last_npc;
        n_commit  = '0;
        npc_next  = last_npc;
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            commit_en[i] = chain_ok
                        && (rob_cnt_t'(i) < count)
                        && finished[raddr[i]]
                        && !res_fwd[i].excp            // trapping entry never retires
                        && (ent_rdata[i].pc == chain_npc);
            chain_ok  = commit_en[i];                  // keeps lanes contiguous
            chain_npc = res_fwd[i].result.npc;
            if (commit_en[i]) begin
                n_commit = n_commit + rob_cnt_t'(1);
                npc_next = res_fwd[i].result.npc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            front    <= '0;
            count    <= '0;
            last_npc <= RESET_PC;
        end else if (clear) begin
            front <= '0;
            count <= '0;
            if (head_excp) begin
                last_npc <= TRAP_VECTOR;  // handler is the next expected pc
            end
        end else begin
            front    <= front + rob_idx_t'(n_commit);
            count    <= count + alloc_cnt - n_commit;
            last_npc <= npc_next;
        end
    end

endmodule

`default_nettype wire

// File: design/rob_trap_out.sv
`timescale 1ns/100ps
`default_nettype none

module rob_trap_out (
    input  rob_pkg::rob_entry_t [rob_pkg::COMMIT_WIDTH-1:0]     ent_rdata,
    input  rob_pkg::rob_result_t [rob_pkg::COMMIT_WIDTH-1:0]    res_fwd,
    input  rob_pkg::rob_idx_t [rob_pkg::COMMIT_WIDTH-1:0]       raddr,
    input  logic [rob_pkg::COMMIT_WIDTH-1:0]                    commit_en,
    input  logic                                                mispredict,
    input  logic                                                head_excp,
    input  logic [isa_pkg::XLEN-1:0]                            last_npc,
    output rob_pkg::commit_bundle_t [rob_pkg::COMMIT_WIDTH-1:0] commit,
    output rob_pkg::redirect_t                                  redirect,
    output logic                                                exception,
    output logic [isa_pkg::XLEN-1:0]                            epc,
    output logic [isa_pkg::XLEN-1:0]                            cause,
    output logic [isa_pkg::XLEN-1:0]                            tval
);
    import rob_pkg::*;
    import isa_pkg::*;

    trap_info_t head_trap;

    always_comb begin
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            commit[i].valid = commit_en[i];
            commit[i].idx   = raddr[i];
            commit[i].pc    = ent_rdata[i].pc;
            commit[i].npc   = res_fwd[i].result.npc;  // npc view of the union
        end
    end

    assign head_trap = res_fwd[0].result.trap;  // trap view, only meaningful on excp

    always_comb begin
        redirect.valid  = mispredict || head_excp;
        redirect.target = head_excp ? TRAP_VECTOR : last_npc;
        exception       = head_excp;
        epc             = head_excp ? ent_rdata[0].pc : '0;
        cause           = head_excp ? XLEN'(head_trap.cause) : '0;  // zero-extended
        tval            = head_excp ? XLEN'(head_trap.tval) : '0;
    end

endmodule

`default_nettype wire

// File: design/rob_top.sv
`timescale 1ns/100ps
`default_nettype none

module rob_top (
    input  logic                                                    clk,
    input  logic                                                    rst,
    input  rob_pkg::dispatch_bundle_t [rob_pkg::DISPATCH_WIDTH-1:0] dispatch,
    input  rob_pkg::exe_bundle_t [rob_pkg::EXE_WIDTH-1:0]           exe_wb,
    output rob_pkg::commit_bundle_t [rob_pkg::COMMIT_WIDTH-1:0]     commit,
    output rob_pkg::redirect_t                                      redirect,
    output logic                                                    exception,
    output logic [isa_pkg::XLEN-1:0]                                epc,
    output logic [isa_pkg::XLEN-1:0]                                cause,
    output logic [isa_pkg::XLEN-1:0]                                tval
);
    import rob_pkg::*;
    import isa_pkg::*;

    rob_idx_t [COMMIT_WIDTH-1:0]      raddr;
    rob_idx_t                         front;
    rob_cnt_t                         count;
    rob_cnt_t                         alloc_cnt;
    rob_idx_t [DISPATCH_WIDTH-1:0]    ent_waddr;
    rob_entry_t [DISPATCH_WIDTH-1:0]  ent_wdata;
    logic [DISPATCH_WIDTH-1:0]        ent_wen;
    rob_entry_t [COMMIT_WIDTH-1:0]    ent_rdata;
    rob_idx_t [EXE_WIDTH-1:0]         res_waddr;
    rob_result_t [EXE_WIDTH-1:0]      res_wdata;
    logic [EXE_WIDTH-1:0]             res_wen;
    rob_result_t [COMMIT_WIDTH-1:0]   res_rdata;
    rob_result_t [COMMIT_WIDTH-1:0]   res_fwd;
    logic [ROB_DEPTH-1:0]             finished;
    logic [COMMIT_WIDTH-1:0]          commit_en;
    logic                             mispredict;
    logic                             head_excp;
    logic                             clear;     // redirect flush
    logic [XLEN-1:0]                  last_npc;

    rob_writeback u_writeback (
        .clk       (clk),
        .rst       (rst),
        .clear     (clear),
        .front     (front),
        .count     (count),
        .dispatch  (dispatch),
        .exe_wb    (exe_wb),
        .raddr     (raddr),
        .ent_waddr (ent_waddr),
        .ent_wdata (ent_wdata),
        .ent_wen   (ent_wen),
        .res_waddr (res_waddr),
        .res_wdata (res_wdata),
        .res_wen   (res_wen),
        .res_rdata (res_rdata),
        .finished  (finished),
        .res_fwd   (res_fwd),
        .alloc_cnt (alloc_cnt)
    );

    // pc and compressed flag, written by dispatch
    mwp_ram #(
        .width  ($bits(rob_entry_t)),
        .depth  (ROB_DEPTH),
        .wports (DISPATCH_WIDTH),
        .rports (COMMIT_WIDTH)
    ) u_ent_ram (
        .clk   (clk),
        .waddr (ent_waddr),
        .wdata (ent_wdata),
        .wen   (ent_wen),
        .raddr (raddr),
        .rdata (ent_rdata)
    );

    // execute results, written by the execute units
    mwp_ram #(
        .width  ($bits(rob_result_t)),
        .depth  (ROB_DEPTH),
        .wports (EXE_WIDTH),
        .rports (COMMIT_WIDTH)
    ) u_res_ram (
        .clk   (clk),
        .waddr (res_waddr),
        .wdata (res_wdata),
        .wen   (res_wen),
        .raddr (raddr),
        .rdata (res_rdata)
    );

    rob_commit_select u_commit_select (
        .clk        (clk),
        .rst        (rst),
        .ent_rdata  (ent_rdata),
        .res_fwd    (res_fwd),
        .finished   (finished),
        .alloc_cnt  (alloc_cnt),
        .raddr      (raddr),
        .front      (front),
        .count      (count),
        .commit_en  (commit_en),
        .mispredict (mispredict),
        .head_excp  (head_excp),
        .clear      (clear),
        .last_npc   (last_npc)
    );

    rob_trap_out u_trap_out (
        .ent_rdata  (ent_rdata),
        .res_fwd    (res_fwd),
        .raddr      (raddr),
        .commit_en  (commit_en),
        .mispredict (mispredict),
        .head_excp  (head_excp),
        .last_npc   (last_npc),
        .commit     (commit),
        .redirect   (redirect),
        .exception  (exception),
        .epc        (epc),
        .cause      (cause),
        .tval       (tval)
    );

endmodule

`default_nettype wire

// File: sim/rob_assert.sv
`timescale 1ns/100ps
`default_nettype none

module rob_assert (
    input logic                                                clk,
    input logic                                                rst,
    input rob_pkg::commit_bundle_t [rob_pkg::COMMIT_WIDTH-1:0] commit,
    input rob_pkg::redirect_t                                  redirect,
    input logic                                                exception,
    input rob_pkg::rob_cnt_t                                   count
);
    import rob_pkg::*;

    logic [COMMIT_WIDTH-1:0] valids;

    always_comb begin
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            valids[i] = commit[i].valid;
        end
    end

    // valid lanes form a run of ones from lane 0
    a_contiguous: assert property (@(posedge clk) disable iff (rst)
        (valids & (valids + COMMIT_WIDTH'(1))) == '0)
        else $error("commit valids are not contiguous from lane 0");

    a_no_commit_on_redirect: assert property (@(posedge clk) disable iff (rst)
        redirect.valid |-> (valids == '0))
        else $error("commit valid together with redirect");

    a_exception_redirects: assert property (@(posedge clk) disable iff (rst)
        exception |-> redirect.valid)
        else $error("exception without redirect");

    a_flush_empties: assert property (@(posedge clk) disable iff (rst)
        redirect.valid |=> (count == '0))
        else $error("buffer not empty after redirect");

endmodule

bind rob_top rob_assert u_assert (
    .clk       (clk),
    .rst       (rst),
    .commit    (commit),
    .redirect  (redirect),
    .exception (exception),
    .count     (count)
);

`default_nettype wire

// File: sim/rob_tb.sv
`timescale 1ns/100ps
`default_nettype none

module rob_tb;
    import isa_pkg::*;
    import rob_pkg::*;

    localparam int NROWS   = 13;
    localparam int MAX_OPS = 8;
    localparam int LIMIT   = NROWS * (MAX_OPS + 20);  // cycles after reset

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] npc;
        logic            excp;
        exc_cause_t      cause;
        logic [57:0]     tval;
    } op_t;

    typedef struct {
        string           name;
        logic [XLEN-1:0] start;    // zero follows the expected chain
        int              n;
        int              jump_at;  // op with a taken branch
        int              brk_at;   // op fetched off the chain
        int              exc_at;   // op that traps
        exc_cause_t      cause;
        logic            late;     // oldest op written back last
    } row_t;

    row_t rows [NROWS] = '{
        '{"reset_wrong_pc", 64'hc000_0040, 3, -1, -1, -1, exc_ecall, 1'b0},
        '{"reset_chain",    64'h0,         8,  3, -1, -1, exc_ecall, 1'b0},
        '{"late_oldest",    64'h0,         7,  5, -1, -1, exc_ecall, 1'b1},
        '{"chain_break",    64'h0,         6, -1,  3, -1, exc_ecall, 1'b0},
        '{"after_break",    64'h0,         5,  1, -1, -1, exc_ecall, 1'b1},
        '{"trap_mid",       64'h0,         6, -1, -1,  2, exc_illegal_inst, 1'b0},
        '{"handler",        64'h0,         8,  6, -1, -1, exc_ecall, 1'b0},
        '{"trap_head",      64'h0,         4, -1, -1,  0, exc_load_fault, 1'b1},
        '{"break_head",     64'h0,         3, -1,  0, -1, exc_ecall, 1'b0},
        '{"wrap_long",      64'h0,         8,  2, -1, -1, exc_ecall, 1'b0},
        '{"wrap_late",      64'h0,         8,  7, -1, -1, exc_ecall, 1'b1},
        '{"ring_trap",      64'h0,         8, -1, -1,  7, exc_breakpoint, 1'b0},
        '{"final_chain",    64'h0,         4, -1, -1, -1, exc_ecall, 1'b0}
    };

    logic                                 clk = 1'b0;
    logic                                 rst;
    dispatch_bundle_t [DISPATCH_WIDTH-1:0] dispatch;
    exe_bundle_t [EXE_WIDTH-1:0]          exe_wb;
    commit_bundle_t [COMMIT_WIDTH-1:0]    commit;
    redirect_t                            redirect;
    logic                                 exception;
    logic [XLEN-1:0]                      epc;
    logic [XLEN-1:0]                      cause;
    logic [XLEN-1:0]                      tval;

    op_t             ops [MAX_OPS];
    int              order [MAX_OPS];       // writeback order
    logic [31:0]     lcg_state = 32'h84f9;
    logic [XLEN-1:0] model_npc;             // expected last committed npc
    rob_idx_t        alloc_ptr;             // slot of the next dispatch
    int              cycles = 0;

    rob_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .dispatch  (dispatch),
        .exe_wb    (exe_wb),
        .commit    (commit),
        .redirect  (redirect),
        .exception (exception),
        .epc       (epc),
        .cause     (cause),
        .tval      (tval)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        if (!rst) begin
            cycles <= cycles + 1;
            if (cycles >= LIMIT) begin
                $display("timeout: run still busy after %0d cycles", cycles);
                halt_failed();
            end
        end
    end

    task automatic halt_failed();
        $display("Something failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_commit(input string name, input commit_bundle_t exp,
                                input commit_bundle_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            halt_failed();
        end
    endtask

    task automatic check_redirect(input string name, input redirect_t exp, input redirect_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            halt_failed();
        end
    endtask

    task automatic check_trap(
        input string           name,
        input logic            exp_exc,
        input logic [XLEN-1:0] exp_epc,
        input logic [XLEN-1:0] exp_cause,
        input logic [XLEN-1:0] exp_tval,
        input logic            act_exc,
        input logic [XLEN-1:0] act_epc,
        input logic [XLEN-1:0] act_cause,
        input logic [XLEN-1:0] act_tval
    );
        if ({act_exc, act_epc, act_cause, act_tval} !==
            {exp_exc, exp_epc, exp_cause, exp_tval}) begin
            $display("[ERROR] %s: expected exc/epc/cause/tval %b %h %h %h, actual %b %h %h %h",
                     name, exp_exc, exp_epc, exp_cause, exp_tval,
                     act_exc, act_epc, act_cause, act_tval);
            halt_failed();
        end
    endtask

    task automatic build_ops(input row_t r);
        logic [XLEN-1:0] pc;
        int              top;
        int              j;
        int              t;
        pc = (r.start != '0) ? r.start : model_npc;
        for (int k = 0; k < r.n; k++) begin
            if (k == r.brk_at) begin
                pc = pc + 64'd8;  // off the predicted path
            end
            ops[k].pc    = pc;
            ops[k].npc   = (k == r.jump_at) ? pc + 64'h100 : pc + 64'd4;
            ops[k].excp  = (k == r.exc_at);
            ops[k].cause = r.cause;
            ops[k].tval  = pc[57:0] ^ 58'h3a5;
            pc           = ops[k].npc;
            order[k]     = r.late ? (k + 1) % r.n : k;  // op 0 parked at the end
        end
        top = r.late ? r.n - 2 : r.n - 1;
        for (int k = top; k > 0; k--) begin
            lcg_state = lcg_next(lcg_state);
            j         = int'(lcg_state[23:8]) % (k + 1);
            t         = order[k];
            order[k]  = order[j];
            order[j]  = t;
        end
    endtask

    task automatic run_row(input row_t r);
        logic [XLEN-1:0] npc;
        redirect_t       exp_redir;
        logic            exp_exc;
        logic [XLEN-1:0] exp_epc;
        logic [XLEN-1:0] exp_cause;
        logic [XLEN-1:0] exp_tval;
        int              exp_n;
        int              sent;
        int              wb;
        int              seen;
        int              k;
        bit              row_done;
        build_ops(r);
        npc       = model_npc;  // retire in order until a chain break or a trap
        exp_n     = r.n;
        exp_redir = '0;
        exp_exc   = 1'b0;
        exp_epc   = '0;
        exp_cause = '0;
        exp_tval  = '0;
        for (int c = 0; c < r.n; c++) begin
            if (ops[c].pc != npc) begin
                exp_n     = c;
                exp_redir = redirect_t'{1'b1, npc};
                break;
            end
            if (ops[c].excp) begin
                exp_n     = c;
                exp_redir = redirect_t'{1'b1, TRAP_VECTOR};
                exp_exc   = 1'b1;
                exp_epc   = ops[c].pc;
                exp_cause = {58'b0, ops[c].cause};
                exp_tval  = {6'b0, ops[c].tval};
                break;
            end
            npc = ops[c].npc;
        end
        sent     = 0;
        wb       = 0;
        seen     = 0;
        row_done = 1'b0;
        while (!row_done) begin
            @(negedge clk);
            dispatch = '0;
            exe_wb   = '0;
            if (sent < r.n) begin
                for (int i = 0; i < DISPATCH_WIDTH; i++) begin
                    if (sent < r.n) begin
                        dispatch[i].valid      = 1'b1;
                        dispatch[i].idx        = alloc_ptr + rob_idx_t'(sent);
                        dispatch[i].pc         = ops[sent].pc;
                        dispatch[i].compressed = sent[0];
                        sent++;
                    end
                end
            end else begin
                for (int i = 0; i < EXE_WIDTH; i++) begin
                    if (wb < r.n) begin
                        k               = order[wb];
                        exe_wb[i].valid = 1'b1;
                        exe_wb[i].idx   = alloc_ptr + rob_idx_t'(k);
                        exe_wb[i].excp  = ops[k].excp;
                        if (ops[k].excp) begin
                            exe_wb[i].result.trap.cause = ops[k].cause;
                            exe_wb[i].result.trap.tval  = ops[k].tval;
                        end else begin
                            exe_wb[i].result.npc = ops[k].npc;
                        end
                        wb++;
                    end
                end
            end
            #10;  // outputs settle well before the next rising edge
            for (int i = 0; i < COMMIT_WIDTH; i++) begin
                if (commit[i].valid) begin
                    if (seen >= exp_n) begin
                        $display("%s: lane %0d committed past the %0d expected ops",
                                 r.name, i, exp_n);
                        halt_failed();
                    end
                    check_commit(r.name, commit_bundle_t'{1'b1, alloc_ptr + rob_idx_t'(seen),
                                 ops[seen].pc, ops[seen].npc}, commit[i]);
                    seen++;
                end
            end
            if (redirect.valid) begin
                if (!exp_redir.valid || seen != exp_n) begin
                    $display("%s: redirect after %0d commits was not expected", r.name, seen);
                    halt_failed();
                end
                check_redirect(r.name, exp_redir, redirect);
                check_trap(r.name, exp_exc, exp_epc, exp_cause, exp_tval,
                           exception, epc, cause, tval);
                row_done = 1'b1;
            end else if (!exp_redir.valid && seen == exp_n) begin
                row_done = 1'b1;
            end
        end
        model_npc = exp_redir.valid ? exp_redir.target : npc;
        alloc_ptr = exp_redir.valid ? '0 : alloc_ptr + rob_idx_t'(r.n);  // flush restarts at 0
    endtask

    initial begin
        rst       = 1'b1;
        dispatch  = '0;
        exe_wb    = '0;
        model_npc = RESET_PC;
        alloc_ptr = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #10;
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            if (commit[i].valid) begin
                $display("reset: lane %0d is valid right after reset", i);
                halt_failed();
            end
        end
        if (redirect.valid || exception) begin
            $display("reset: redirect or exception is raised right after reset");
            halt_failed();
        end
        for (int r = 0; r < NROWS; r++) begin
            run_row(rows[r]);
        end
        @(negedge clk);
        dispatch = '0;
        exe_wb   = '0;
        repeat (2) @(negedge clk);
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: rob_top.f
design/isa_pkg.sv
design/rob_pkg.sv
design/mwp_ram.sv
design/rob_writeback.sv
design/rob_commit_select.sv
design/rob_trap_out.sv
design/rob_top.sv
sim/rob_assert.sv
sim/rob_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= rob_tb
FILELIST  ?= rob_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
